//--- hdl/mul_defs.svh
// Build-time parameters of the multiply accelerator.
// Included by the package and by any module or testbench that sizes or decodes with them.
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

`define NUM_LANES    4      // multiply lanes in the array
`define XLEN         32     // operand and result width
`define RESULT_DEPTH 8      // result fifo entries

// apb byte offsets, decoded from an 8-bit paddr
`define ADDR_OPA     8'h00  // operand a (rs1)
`define ADDR_OPB     8'h04  // operand b (rs2)
`define ADDR_CMD     8'h08  // write op code, issues a request
`define ADDR_STATUS  8'h0C  // bit0 result available, bit1 dispatcher busy
`define ADDR_RESULT  8'h10  // read pops the result fifo

`endif

//--- hdl/mul_pkg.sv
// Shared types of the multiply accelerator.
// Modules refer to these by scoped name, e.g. mul_pkg::mul_req_t.
`include "mul_defs.svh"

package mul_pkg;

    // operand / result word
    typedef logic [`XLEN-1:0] word_t;

    // lane pointer used by dispatcher and collector
    typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

    // funct3[1:0] encoding of the m-extension multiplies
    typedef enum logic [1:0] {
        MUL    = 2'd0,  // low word, signedness irrelevant
        MULH   = 2'd1,  // high word, signed x signed
        MULHSU = 2'd2,  // high word, signed x unsigned
        MULHU  = 2'd3   // high word, unsigned x unsigned
    } mul_op_e;

    // apb slave phase tracking
    typedef enum logic {
        IDLE   = 1'b0,  // waiting for a setup phase
        ACCESS = 1'b1   // setup seen, access phase in progress
    } apb_state_e;

    // one multiply request, 66 bits
    typedef struct packed {
        mul_op_e op;
        word_t   rs1;
        word_t   rs2;
    } mul_req_t;

endpackage

//--- hdl/mul_apb_regs.sv
// APB slave front end of the multiply accelerator.
// Holds the operand registers, turns CMD writes into requests (stalling pready
// until the dispatcher takes them) and serves STATUS and RESULT reads.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_apb_regs (
    input  logic              clk,
    input  logic              rst,
    // apb slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  mul_pkg::word_t    pwdata,
    output mul_pkg::word_t    prdata,
    output logic              pready,
    output logic              pslverr,
    // request to dispatcher
    output logic              req_valid,
    input  logic              req_ready,
    output mul_pkg::mul_req_t req,
    input  logic              busy,       // dispatcher holding a request
    // result fifo head
    input  logic              res_avail,
    input  mul_pkg::word_t    res_data,
    output logic              res_pop
);

    mul_pkg::apb_state_e state;
    mul_pkg::word_t      opa;            // rs1 operand
    mul_pkg::word_t      opb;            // rs2 operand
    logic                access;         // valid access phase this cycle
    logic                wr;
    logic                rd;

    assign access = (state == mul_pkg::ACCESS) & psel & penable;
    assign wr     = access & pwrite;
    assign rd     = access & ~pwrite;

    // phase tracker
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mul_pkg::IDLE;
        end else begin
            case (state)
                mul_pkg::IDLE: begin
                    if (psel && !penable)
                        state <= mul_pkg::ACCESS;      // setup phase seen
                end
                mul_pkg::ACCESS: begin
                    if (!psel || (penable && pready))
                        state <= mul_pkg::IDLE;        // transfer done or dropped
                end
                default: state <= mul_pkg::IDLE;
            endcase
        end
    end

    // operand registers, zero wait state
    always_ff @(posedge clk) begin
        if (wr && paddr == `ADDR_OPA)
            opa <= pwdata;
        if (wr && paddr == `ADDR_OPB)
            opb <= pwdata;
    end

    // cmd write is held as a request until accepted
    assign req_valid = wr & (paddr == `ADDR_CMD);
    assign req.op    = mul_pkg::mul_op_e'(pwdata[1:0]);  // funct3[1:0]
    assign req.rs1   = opa;
    assign req.rs2   = opb;
    assign pready    = ~(req_valid & ~req_ready);        // stall only on a blocked cmd

    // read mux, result pop and error
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        res_pop = 1'b0;
        if (rd) begin
            case (paddr)
                `ADDR_OPA:    prdata = opa;
                `ADDR_OPB:    prdata = opb;
                `ADDR_STATUS: prdata[1:0] = {busy, res_avail};
                `ADDR_RESULT: begin
                    if (res_avail) begin
                        prdata  = res_data;            // head word
                        res_pop = 1'b1;                // consumed with this read
                    end else begin
                        pslverr = 1'b1;                // empty fifo, data stays 0
                    end
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

//--- hdl/mul_dispatch.sv
// Request dispatcher: a one-entry holding register that hands each request
// to the lane at the rotation pointer. Lanes are served strictly in turn.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    // from apb block
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mul_pkg::mul_req_t     in_req,
    output logic                  busy,
    // to lanes
    output logic [`NUM_LANES-1:0] lane_valid,
    input  logic [`NUM_LANES-1:0] lane_ready,
    output mul_pkg::mul_req_t     lane_req     // shared by all lanes
);

    logic               hold_valid;
    mul_pkg::mul_req_t  hold_req;
    mul_pkg::lane_idx_t ptr;                   // next lane to feed
    logic               lane_fire;             // transfer to lane this cycle

    assign lane_fire = hold_valid & lane_ready[ptr];
    assign in_ready  = ~hold_valid | lane_fire;   // empty or being emptied
    assign busy      = hold_valid;
    assign lane_req  = hold_req;

    // steer valid to the pointed lane only
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_valid[i] = hold_valid && (ptr == mul_pkg::lane_idx_t'(i));
        end
    end

    // holding register control and rotation
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            ptr        <= '0;
        end else begin
            if (in_ready)
                hold_valid <= in_valid;
            if (lane_fire) begin
                if (ptr == mul_pkg::lane_idx_t'(`NUM_LANES - 1))
                    ptr <= '0;                 // wrap
                else
                    ptr <= ptr + 1'b1;
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            hold_req <= in_req;
    end

endmodule

//--- hdl/mul_lane.sv
// One multiply lane: 33x33 signed multiply in two registered stages.
// Stage 1 holds the sign-extended operands, stage 2 the 66-bit product.
// A stage advances when it is empty or its contents move on.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_lane (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  mul_pkg::mul_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output mul_pkg::word_t    rsp
);

    logic [1:0]                 valid;     // per-stage occupancy
    logic [1:0]                 advance;   // stage may load
    logic [1:0]                 hi;        // return upper word
    logic                       rs1_signed;
    logic                       rs2_signed;
    logic signed [`XLEN:0]      rs1_ext;
    logic signed [`XLEN:0]      rs2_ext;
    logic signed [`XLEN:0]      rs1_r;
    logic signed [`XLEN:0]      rs2_r;
    logic signed [2*`XLEN+1:0]  prod_r;

    assign advance[1] = rsp_ready | ~valid[1];
    assign advance[0] = ~valid[0] | advance[1];
    assign req_ready  = advance[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (advance[0])
                valid[0] <= req_valid;
            if (advance[1])
                valid[1] <= valid[0];
        end
    end

    // mul ignores signedness of the low word
    assign rs1_signed = req.op inside {mul_pkg::MULH, mul_pkg::MULHSU};
    assign rs2_signed = (req.op == mul_pkg::MULH);
    assign rs1_ext    = signed'({req.rs1[`XLEN-1] & rs1_signed, req.rs1});
    assign rs2_ext    = signed'({req.rs2[`XLEN-1] & rs2_signed, req.rs2});

    always_ff @(posedge clk) begin
        if (req_valid && advance[0]) begin
            rs1_r <= rs1_ext;
            rs2_r <= rs2_ext;
            hi[0] <= (req.op != mul_pkg::MUL);
        end
        if (valid[0] && advance[1]) begin
            prod_r <= rs1_r * rs2_r;           // full signed product
            hi[1]  <= hi[0];
        end
    end

    assign rsp_valid = valid[1];
    assign rsp       = hi[1] ? prod_r[2*`XLEN-1:`XLEN] : prod_r[`XLEN-1:0];

endmodule

//--- hdl/mul_collect.sv
// Result collector: drains the lanes in the same rotation as the dispatcher,
// so results keep issue order, and queues them in a circular result FIFO
// whose head is read by the APB block.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_collect (
    input  logic                  clk,
    input  logic                  rst,
    // from lanes
    input  logic [`NUM_LANES-1:0] lane_valid,
    output logic [`NUM_LANES-1:0] lane_ready,
    input  mul_pkg::word_t        lane_rsp [`NUM_LANES],
    // fifo head
    output logic                  res_avail,
    output mul_pkg::word_t        res_data,
    input  logic                  res_pop
);

    typedef logic [$clog2(`RESULT_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(`RESULT_DEPTH+1)-1:0] fifo_cnt_t;

    mul_pkg::word_t     mem [`RESULT_DEPTH];
    fifo_ptr_t          wr_ptr;                // tail
    fifo_ptr_t          rd_ptr;                // head
    fifo_cnt_t          count;
    logic               full;
    logic               push;
    logic               pop;
    mul_pkg::lane_idx_t ptr;                   // lane expected next

    assign full      = (count == fifo_cnt_t'(`RESULT_DEPTH));
    assign push      = lane_valid[ptr] & ~full;
    assign pop       = res_pop & res_avail;    // ignore pops on empty
    assign res_avail = (count != '0);
    assign res_data  = mem[rd_ptr];

    // ready only at pointer and only with room
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_ready[i] = ~full && (ptr == mul_pkg::lane_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr    <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                ptr    <= (ptr == mul_pkg::lane_idx_t'(`NUM_LANES - 1)) ? '0 : ptr + 1'b1;
                wr_ptr <= (wr_ptr == fifo_ptr_t'(`RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
                rd_ptr <= (rd_ptr == fifo_ptr_t'(`RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= lane_rsp[ptr];
    end

endmodule

//--- hdl/mul_array_top.sv
// Top level of the APB multiply accelerator.
// Connects the APB registers, the dispatcher, the lane array and the collector.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_array_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [7:0]     paddr,
    input  mul_pkg::word_t pwdata,
    output mul_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr
);

    logic                  req_valid;
    logic                  req_ready;
    mul_pkg::mul_req_t     req;
    logic                  busy;
    logic [`NUM_LANES-1:0] lane_req_valid;
    logic [`NUM_LANES-1:0] lane_req_ready;
    mul_pkg::mul_req_t     lane_req;         // broadcast to all lanes
    logic [`NUM_LANES-1:0] lane_rsp_valid;
    logic [`NUM_LANES-1:0] lane_rsp_ready;
    mul_pkg::word_t        lane_rsp [`NUM_LANES];
    logic                  res_avail;
    mul_pkg::word_t        res_data;
    logic                  res_pop;

    mul_apb_regs u_apb_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .busy     (busy),
        .res_avail(res_avail),
        .res_data (res_data),
        .res_pop  (res_pop)
    );

    mul_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .busy      (busy),
        .lane_valid(lane_req_valid),
        .lane_ready(lane_req_ready),
        .lane_req  (lane_req)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        mul_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .req_valid(lane_req_valid[i]),
            .req_ready(lane_req_ready[i]),
            .req      (lane_req),
            .rsp_valid(lane_rsp_valid[i]),
            .rsp_ready(lane_rsp_ready[i]),
            .rsp      (lane_rsp[i])
        );
    end

    mul_collect u_collect (
        .clk       (clk),
        .rst       (rst),
        .lane_valid(lane_rsp_valid),
        .lane_ready(lane_rsp_ready),
        .lane_rsp  (lane_rsp),
        .res_avail (res_avail),
        .res_data  (res_data),
        .res_pop   (res_pop)
    );

endmodule

//--- sim/mul_array_tb.sv
// Directed testbench for the APB multiply accelerator.
// Drives the APB port, models each op in ref_mul and checks results in issue order.
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_array_tb;

    localparam int NUM_OPS  = 16 + 12 + 20 + 1 + 200;  // multiplies issued over all tests
    localparam int LIMIT_NS = 20 * NUM_OPS * 40;

    logic           clk;
    logic           rst;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [7:0]     paddr;
    mul_pkg::word_t pwdata;
    mul_pkg::word_t prdata;
    logic           pready;
    logic           pslverr;

    mul_pkg::word_t expected [$];  // model results, oldest first
    mul_pkg::word_t rdata;         // data of the last apb read
    logic           rerr;          // pslverr of the last transfer

    mul_array_top u_mul_array_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, tests did not finish within %0d ns", LIMIT_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input mul_pkg::word_t exp, input mul_pkg::word_t act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // 33-bit extension per op, low word for mul, high word otherwise
    function automatic mul_pkg::word_t ref_mul(input mul_pkg::mul_op_e op,
                                               input mul_pkg::word_t a,
                                               input mul_pkg::word_t b);
        logic signed [`XLEN:0]     a_ext;
        logic signed [`XLEN:0]     b_ext;
        logic signed [2*`XLEN+1:0] prod;
        a_ext = {(op == mul_pkg::MULH || op == mul_pkg::MULHSU) ? a[`XLEN-1] : 1'b0, a};
        b_ext = {(op == mul_pkg::MULH) ? b[`XLEN-1] : 1'b0, b};  // only mulh signs rs2
        prod  = a_ext * b_ext;
        return (op == mul_pkg::MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
    endfunction

    // one setup + access transfer, sampled at negedge where pready is stable
    task automatic bus_transfer(input logic wr, input logic [7:0] addr, input mul_pkg::word_t data);
        @(posedge clk);
        psel    <= 1'b1;   // setup
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;   // access
        do begin
            @(negedge clk);
        end while (!pready);  // cmd writes wait here under back-pressure
        rdata = prdata;
        rerr  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input mul_pkg::word_t data);
        bus_transfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        bus_transfer(1'b0, addr, '0);
    endtask

    task automatic issue(input mul_pkg::mul_op_e op, input mul_pkg::word_t a,
                         input mul_pkg::word_t b);
        apb_write(`ADDR_OPA, a);
        apb_write(`ADDR_OPB, b);
        apb_write(`ADDR_CMD, mul_pkg::word_t'(op));
        expected.push_back(ref_mul(op, a, b));
    endtask

    // poll status bit0, then pop one result and compare with the oldest model value
    task automatic fetch_result(input string name);
        mul_pkg::word_t exp;
        rdata = '0;
        while (rdata[0] !== 1'b1) begin
            apb_read(`ADDR_STATUS);
        end
        apb_read(`ADDR_RESULT);
        check({name, " pslverr"}, '0, mul_pkg::word_t'(rerr));
        exp = expected.pop_front();
        check(name, exp, rdata);
    endtask

    task automatic drain(input string name);
        while (expected.size() != 0) begin
            fetch_result(name);
        end
    endtask

    // command held open in access phase, must not complete while everything is full
    task automatic probe_cmd_stall();
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= `ADDR_CMD;
        pwdata  <= '0;
        @(posedge clk);
        penable <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            check("backpressure pready", '0, mul_pkg::word_t'(pready));
        end
        @(posedge clk);
        psel    <= 1'b0;  // abandon, nothing was accepted
        penable <= 1'b0;
    endtask

    task automatic corner_operands();
        mul_pkg::word_t x;
        x = $urandom;
        for (int op = 0; op < 4; op++) begin
            issue(mul_pkg::mul_op_e'(op), 32'h8000_0000, 32'hFFFF_FFFF);
            issue(mul_pkg::mul_op_e'(op), 32'h7FFF_FFFF, 32'h7FFF_FFFF);  // signed max
            issue(mul_pkg::mul_op_e'(op), 32'hFFFF_FFFF, 32'hFFFF_FFFF);  // unsigned max
            issue(mul_pkg::mul_op_e'(op), 32'h0, x);
            drain("corners");
        end
    endtask

    task automatic back_to_back_stream();
        for (int i = 0; i < 12; i++) begin
            issue(mul_pkg::mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
        end
        drain("stream");
    endtask

    task automatic full_pipeline_backpressure();
        for (int i = 0; i < 17; i++) begin  // 8 fifo + 8 lanes + 1 dispatcher
            issue(mul_pkg::mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
        end
        apb_read(`ADDR_STATUS);
        check("backpressure status", 32'h3, rdata);  // results waiting, dispatcher full
        probe_cmd_stall();
        for (int i = 17; i < 20; i++) begin
            fetch_result("backpressure");
            issue(mul_pkg::mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
        end
        drain("backpressure");
    endtask

    task automatic empty_fifo_read();
        apb_read(`ADDR_RESULT);
        check("empty pslverr", 32'h1, mul_pkg::word_t'(rerr));
        check("empty data", '0, rdata);
        apb_read(`ADDR_STATUS);
        check("empty status bit0", '0, mul_pkg::word_t'(rdata[0]));
        issue(mul_pkg::MULHU, $urandom, $urandom);
        fetch_result("status poll");  // waits for bit0 to rise
    endtask

    task automatic random_operands();
        for (int i = 0; i < 200; i++) begin
            issue(mul_pkg::mul_op_e'($urandom_range(3, 0)), $urandom, $urandom);
            if (expected.size() >= 16 || $urandom_range(1, 0) == 1) begin
                fetch_result("random");  // bounded backlog keeps cmds from stalling for good
            end
        end
        drain("random");
    endtask

    initial begin
        void'($urandom(32'h3452_c1f8));
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        corner_operands();
        back_to_back_stream();
        full_pipeline_backpressure();
        empty_fifo_read();
        random_operands();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- mul_array_top.f
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_apb_regs.sv
hdl/mul_dispatch.sv
hdl/mul_lane.sv
hdl/mul_collect.sv
hdl/mul_array_top.sv
sim/mul_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run into sim.log, decide on the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f mul_array_top.f --top-module mul_array_tb \
    -o mul_array_tb > build.log 2>&1 \
    && ./obj_dir/mul_array_tb > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
